/* files.f */
+incdir+hw
hw/tdc_event_pkg.sv
hw/his_readout_pkg.sv
hw/event_router.sv
hw/his_bank.sv
hw/his_drain.sv
hw/his_top.sv
verif/tb_clk_gen.sv
verif/his_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the histogram testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module his_tb -Mdir obj_dir -f files.f \
    && ./obj_dir/Vhis_tb | tee /dev/stderr | grep "^TEST OK$" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verif/his_tb.sv */
`timescale 1ns/1ps

`include "his_settings.svh"

module his_tb
    import tdc_event_pkg::*;
    import his_readout_pkg::*;
();

    localparam int PIX_TOT      = `BANK_NUM * `PIXEL_PER_BANK;
    localparam int ENTRY_TOT    = PIX_TOT * `BIN_NB;
    localparam int ENTRY_W      = `BANK_W + `PIXEL_W + `BIN_W;
    localparam int FRAME_NB     = 4;
    localparam int FRAME_GAP    = 300;
    localparam int SAT_HITS     = 300;
    localparam int RD_PER_FRAME = ENTRY_TOT;
    // frame-ending marker edge to frame_done sample edge
    localparam int DONE_LAT     = 261;
    localparam int WATCHDOG_CYC = (FRAME_NB + 1) * FRAME_GAP + SAT_HITS + 200;
    localparam count_t CNT_TOP  = {`COUNT_W{1'b1}};
    localparam logic [`BIN_W-1:0] TOP_BIN = `BIN_W'(`BIN_NB - 1);

    logic                clk;
    logic                combin_res;
    logic                ev_strobe;
    event_word_u         ev_word;
    logic                rd_valid;
    logic [`BANK_W-1:0]  rd_bank;
    logic [`PIXEL_W-1:0] rd_pixel;
    logic [`BIN_W-1:0]   rd_bin;
    count_t              rd_count;
    logic                peak_valid;
    logic [`BANK_W-1:0]  peak_bank;
    logic [`PIXEL_W-1:0] peak_pixel;
    logic [`BIN_W-1:0]   peak_bin;
    count_t              peak_count;
    logic                frame_done;
    logic                seq_error;

    // reference model state
    count_t              model_cnt [ENTRY_TOT] = '{default: '0};
    count_t              exp_cnt [ENTRY_TOT] = '{default: '0};
    count_t              exp_pk_cnt [PIX_TOT] = '{default: '0};
    logic [`BIN_W-1:0]   exp_pk_bin [PIX_TOT] = '{default: '0};
    int                  acq_cnt = 0;
    logic [`SEQ_W-1:0]   last_seq = '0;
    logic [`SEQ_W-1:0]   seq_follow;
    logic                seq_seen = 1'b0;
    logic                exp_seq_err = 1'b0;
    int                  cyc = 0;
    int                  swap_cyc = 0;
    logic                have_swap = 1'b0;
    int                  rdv_cnt = 0;
    int                  done_cnt = 0;
    int                  seq_err_seen = 0;
    int                  mismatch_cnt = 0;
    int                  fail_cnt = 0;
    integer              seed = 37390;
    logic [`SEQ_W-1:0]   seq_next = 7'd120;
    logic [ENTRY_W-1:0]  exp_rd_idx;
    count_t              exp_rd_count;
    count_t              exp_peak_count;
    logic [`BIN_W-1:0]   exp_peak_bin;

    tb_clk_gen #(.PERIOD_NS(10), .RESET_CYC(2)) i_clk_gen (
        .clk        (clk),
        .combin_res (combin_res)
    );

    his_top i_dut (
        .clk        (clk),
        .combin_res (combin_res),
        .ev_strobe  (ev_strobe),
        .ev_word    (ev_word),
        .rd_valid   (rd_valid),
        .rd_bank    (rd_bank),
        .rd_pixel   (rd_pixel),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count),
        .peak_valid (peak_valid),
        .peak_bank  (peak_bank),
        .peak_pixel (peak_pixel),
        .peak_bin   (peak_bin),
        .peak_count (peak_count),
        .frame_done (frame_done),
        .seq_error  (seq_error)
    );

    // sequence number wraps at its width
    assign seq_follow     = last_seq + 1'b1;
    // n-th result of a walk belongs to entry n in bank, pixel, bin order
    assign exp_rd_idx     = rdv_cnt[ENTRY_W-1:0];
    assign exp_rd_count   = exp_cnt[exp_rd_idx];
    assign exp_peak_count = exp_pk_cnt[exp_rd_idx[ENTRY_W-1:`BIN_W]];
    assign exp_peak_bin   = exp_pk_bin[exp_rd_idx[ENTRY_W-1:`BIN_W]];

    // model follows the event stream edge by edge
    always @(posedge clk) begin : model_upd
        int i;
        int p;
        int b;
        count_t best;
        logic [`BIN_W-1:0] best_bin;
        logic [ENTRY_W-1:0] idx;
        cyc         <= cyc + 1;
        exp_seq_err <= 1'b0;
        if (rd_valid) rdv_cnt <= rdv_cnt + 1;
        if (frame_done) done_cnt <= done_cnt + 1;
        if (seq_error) seq_err_seen <= seq_err_seen + 1;
        if (combin_res && ev_strobe) begin
            if (ev_word.photon.tag == EV_TAG_PHOTON) begin
                idx = {ev_word.photon.bank, ev_word.photon.pixel, ev_word.photon.bin};
                // count sticks at the top value
                if (model_cnt[idx] != CNT_TOP) model_cnt[idx] = model_cnt[idx] + 1'b1;
            end else begin
                // any marker after the first must follow on by one
                exp_seq_err <= seq_seen && (ev_word.marker.seq != seq_follow);
                last_seq    <= ev_word.marker.seq;
                seq_seen    <= 1'b1;
                if (acq_cnt == `ACQ_NUM - 1) begin
                    acq_cnt <= 0;
                    // peak per pixel with the lower bin winning a tie
                    for (p = 0; p < PIX_TOT; p++) begin
                        best     = model_cnt[p * `BIN_NB];
                        best_bin = '0;
                        for (b = 1; b < `BIN_NB; b++) begin
                            if (model_cnt[p * `BIN_NB + b] > best) begin
                                best     = model_cnt[p * `BIN_NB + b];
                                best_bin = b[`BIN_W-1:0];
                            end
                        end
                        exp_pk_cnt[p] = best;
                        exp_pk_bin[p] = best_bin;
                    end
                    // finished page becomes the expected readout
                    for (i = 0; i < ENTRY_TOT; i++) begin
                        exp_cnt[i]   = model_cnt[i];
                        model_cnt[i] = '0;
                    end
                    swap_cyc  <= cyc;
                    have_swap <= 1'b1;
                    rdv_cnt   <= 0;
                end else begin
                    acq_cnt <= acq_cnt + 1;
                end
            end
        end
    end

    a_reset_low: assert property (@(posedge clk)
        !combin_res |-> !(rd_valid || peak_valid || frame_done || seq_error))
        else begin
            fail_cnt++;
            $display("outputs were not held low during reset");
        end

    // walk order is bank, then pixel, then bin
    a_rd_order: assert property (@(posedge clk) disable iff (!combin_res)
        rd_valid |-> ({rd_bank, rd_pixel, rd_bin} == exp_rd_idx))
        else begin
            mismatch_cnt++;
            $display("Mismatch rd_order expected %0d actual %0d",
                     $sampled(exp_rd_idx), $sampled({rd_bank, rd_pixel, rd_bin}));
        end

    a_rd_count: assert property (@(posedge clk) disable iff (!combin_res)
        rd_valid |-> (rd_count == exp_rd_count))
        else begin
            mismatch_cnt++;
            $display("Mismatch rd_count b%0d p%0d t%0d expected %0d actual %0d",
                     $sampled(rd_bank), $sampled(rd_pixel), $sampled(rd_bin),
                     $sampled(exp_rd_count), $sampled(rd_count));
        end

    a_peak_bin: assert property (@(posedge clk) disable iff (!combin_res)
        peak_valid |-> (peak_bin == exp_peak_bin))
        else begin
            mismatch_cnt++;
            $display("Mismatch peak_bin expected %0d actual %0d",
                     $sampled(exp_peak_bin), $sampled(peak_bin));
        end

    a_peak_count: assert property (@(posedge clk) disable iff (!combin_res)
        peak_valid |-> (peak_count == exp_peak_count))
        else begin
            mismatch_cnt++;
            $display("Mismatch peak_count expected %0d actual %0d",
                     $sampled(exp_peak_count), $sampled(peak_count));
        end

    // peak comes out with the last bin of its own pixel
    a_peak_align: assert property (@(posedge clk) disable iff (!combin_res)
        peak_valid |-> (rd_valid && (rd_bin == TOP_BIN) &&
                        (rd_bank == peak_bank) && (rd_pixel == peak_pixel)))
        else begin
            fail_cnt++;
            $display("peak result did not line up with the last bin of its pixel");
        end

    a_done_time: assert property (@(posedge clk) disable iff (!combin_res)
        frame_done == (have_swap && (cyc - swap_cyc == DONE_LAT)))
        else begin
            mismatch_cnt++;
            $display("Mismatch frame_done expected %0b actual %0b",
                     $sampled(have_swap && (cyc - swap_cyc == DONE_LAT)),
                     $sampled(frame_done));
        end

    a_rd_per_frame: assert property (@(posedge clk) disable iff (!combin_res)
        frame_done |-> (rdv_cnt == RD_PER_FRAME))
        else begin
            mismatch_cnt++;
            $display("Mismatch rd_valid_count expected %0d actual %0d",
                     RD_PER_FRAME, $sampled(rdv_cnt));
        end

    a_seq_error: assert property (@(posedge clk) disable iff (!combin_res)
        seq_error == exp_seq_err)
        else begin
            mismatch_cnt++;
            $display("Mismatch seq_error expected %0b actual %0b",
                     $sampled(exp_seq_err), $sampled(seq_error));
        end

    function automatic event_word_u photon_word(input logic [`BANK_W-1:0] bank,
                                                input logic [`PIXEL_W-1:0] pixel,
                                                input logic [`BIN_W-1:0] bin);
        event_word_u w;
        w              = '0;
        w.photon.tag   = EV_TAG_PHOTON;
        w.photon.bank  = bank;
        w.photon.pixel = pixel;
        w.photon.bin   = bin;
        return w;
    endfunction

    function automatic event_word_u marker_word(input logic [`SEQ_W-1:0] seq);
        event_word_u w;
        w            = '0;
        w.marker.tag = EV_TAG_MARKER;
        w.marker.seq = seq;
        return w;
    endfunction

    // strobe stays up until the next call changes it
    task automatic send_word(input event_word_u w);
        @(negedge clk);
        ev_strobe = 1'b1;
        ev_word   = w;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            ev_strobe = 1'b0;
        end
    endtask

    task automatic send_photon(input int bank, input int pixel, input int bin);
        send_word(photon_word(bank[`BANK_W-1:0], pixel[`PIXEL_W-1:0], bin[`BIN_W-1:0]));
    endtask

    task automatic send_marker();
        send_word(marker_word(seq_next));
        seq_next = seq_next + 1'b1;
    endtask

    // one number left out of the sequence
    task automatic send_marker_skip();
        seq_next = seq_next + 1'b1;
        send_marker();
    endtask

    task automatic random_photons(input int n);
        int k;
        integer rnd;
        for (k = 0; k < n; k++) begin
            rnd = $random(seed);
            send_word(photon_word(rnd[1:0], rnd[3:2], rnd[7:4]));
            // occasional quiet cycle
            if (rnd[10:9] == 2'b00) idle(1);
        end
    endtask

    // closing marker only once the previous walk is well clear
    task automatic end_frame();
        while (have_swap && ((cyc - swap_cyc) < FRAME_GAP)) idle(1);
        send_marker();
    endtask

    initial begin : stimulus
        int i;
        ev_strobe = 1'b0;
        ev_word   = '0;
        @(posedge combin_res);
        idle(2);

        // frame 0 hits every bank and pixel then a random spread
        for (i = 0; i < PIX_TOT; i++) send_photon(i / 4, i % 4, i);
        send_marker();
        random_photons(100);
        send_marker();
        random_photons(100);
        end_frame();

        // frame 1 lands during the frame 0 walk
        repeat (SAT_HITS) send_photon(2, 1, 7);
        send_marker();
        repeat (10) send_photon(2, 1, 2);
        // bins 4 and 10 tie on this pixel
        repeat (6) begin
            send_photon(1, 3, 10);
            send_photon(1, 3, 4);
        end
        repeat (3) send_photon(1, 3, 12);
        send_marker();
        send_photon(3, 0, 15);
        send_photon(0, 2, 0);
        end_frame();

        // frame 2 reuses the frame 0 page with sparse hits
        send_marker();
        random_photons(20);
        send_marker();
        end_frame();

        // frame 3 reuses the saturated page with no hits and one sequence gap
        send_marker();
        send_marker_skip();
        end_frame();
        idle(1);

        wait (done_cnt == FRAME_NB);
        idle(4);

        a_seq_once: assert (seq_err_seen == 1)
            else begin
                fail_cnt++;
                $display("seq_error pulsed %0d times instead of once", seq_err_seen);
            end

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if ((mismatch_cnt == 0) && (fail_cnt == 0)) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 10,
    parameter int RESET_CYC = 2
) (
    output logic clk,
    output logic combin_res
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // real falling edge so the async resets fire
    initial begin
        combin_res = 1'b1;
        #1 combin_res = 1'b0;
        repeat (RESET_CYC) @(posedge clk);
        // release away from the active edge
        @(negedge clk);
        combin_res = 1'b1;
    end

endmodule

/* hw/his_top.sv */
`timescale 1ns/1ps

`include "his_settings.svh"

module his_top
    import tdc_event_pkg::*;
    import his_readout_pkg::*;
(
    input  logic                clk,
    input  logic                combin_res,
    input  logic                ev_strobe,
    input  event_word_u         ev_word,
    output logic                rd_valid,
    output logic [`BANK_W-1:0]  rd_bank,
    output logic [`PIXEL_W-1:0] rd_pixel,
    output logic [`BIN_W-1:0]   rd_bin,
    output count_t              rd_count,
    output logic                peak_valid,
    output logic [`BANK_W-1:0]  peak_bank,
    output logic [`PIXEL_W-1:0] peak_pixel,
    output logic [`BIN_W-1:0]   peak_bin,
    output count_t              peak_count,
    output logic                frame_done,
    output logic                seq_error
);

    // router to banks
    logic [`BANK_NUM-1:0] hit_en;
    bin_addr_t            hit_addr;
    logic                 page_swap;

    // drain side of the banks
    bin_addr_t            rd_addr;
    count_t               bank_count [`BANK_NUM];

    event_router i_router (
        .clk        (clk),
        .combin_res (combin_res),
        .ev_strobe  (ev_strobe),
        .ev_word    (ev_word),
        .hit_en     (hit_en),
        .hit_addr   (hit_addr),
        .page_swap  (page_swap),
        .seq_error  (seq_error)
    );

    // one bank per hit_en bit
    for (genvar g = 0; g < `BANK_NUM; g++) begin : g_bank
        his_bank i_bank (
            .clk        (clk),
            .combin_res (combin_res),
            .hit_en     (hit_en[g]),
            .hit_addr   (hit_addr),
            .page_swap  (page_swap),
            .rd_addr    (rd_addr),
            .rd_count   (bank_count[g])
        );
    end

    his_drain i_drain (
        .clk        (clk),
        .combin_res (combin_res),
        .page_swap  (page_swap),
        .bank_count (bank_count),
        .rd_addr    (rd_addr),
        .rd_valid   (rd_valid),
        .rd_bank    (rd_bank),
        .rd_pixel   (rd_pixel),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count),
        .peak_valid (peak_valid),
        .peak_bank  (peak_bank),
        .peak_pixel (peak_pixel),
        .peak_bin   (peak_bin),
        .peak_count (peak_count),
        .frame_done (frame_done)
    );

endmodule

/* hw/his_drain.sv */
`timescale 1ns/1ps

`include "his_settings.svh"

module his_drain
    import his_readout_pkg::*;
(
    input  logic                clk,
    input  logic                combin_res,
    input  logic                page_swap,
    input  count_t              bank_count [`BANK_NUM],
    output bin_addr_t           rd_addr,
    output logic                rd_valid,
    output logic [`BANK_W-1:0]  rd_bank,
    output logic [`PIXEL_W-1:0] rd_pixel,
    output logic [`BIN_W-1:0]   rd_bin,
    output count_t              rd_count,
    output logic                peak_valid,
    output logic [`BANK_W-1:0]  peak_bank,
    output logic [`PIXEL_W-1:0] peak_pixel,
    output logic [`BIN_W-1:0]   peak_bin,
    output count_t              peak_count,
    output logic                frame_done
);

    localparam logic [`BANK_W-1:0]  LAST_BANK  = `BANK_W'(`BANK_NUM - 1);
    localparam logic [`PIXEL_W-1:0] LAST_PIXEL = `PIXEL_W'(`PIXEL_PER_BANK - 1);
    localparam logic [`BIN_W-1:0]   LAST_BIN   = `BIN_W'(`BIN_NB - 1);

    // walker state
    logic                busy;
    logic                wk_last;
    logic [`BANK_W-1:0]  wk_bank;
    logic [`PIXEL_W-1:0] wk_pixel;
    logic [`BIN_W-1:0]   wk_bin;

    // stage 0 is address out, stage 1 is bank read
    logic                v0;
    logic                v1;
    logic [`BANK_W-1:0]  t0_bank;
    logic [`BANK_W-1:0]  t1_bank;
    logic [`PIXEL_W-1:0] t0_pixel;
    logic [`PIXEL_W-1:0] t1_pixel;
    logic [`BIN_W-1:0]   t0_bin;
    logic [`BIN_W-1:0]   t1_bin;

    // running peak of the current pixel
    count_t              max_count;
    logic [`BIN_W-1:0]   max_bin;
    count_t              sel_count;
    logic                take_new;

    assign wk_last = (wk_bank == LAST_BANK) && (wk_pixel == LAST_PIXEL) && (wk_bin == LAST_BIN);

    // returning count picked by bank tag
    assign sel_count = bank_count[t1_bank];
    // strictly greater so ties keep the lower bin
    assign take_new  = (t1_bin == '0) || (sel_count > max_count);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            busy     <= 1'b0;
            wk_bank  <= '0;
            wk_pixel <= '0;
            wk_bin   <= '0;
            v0       <= 1'b0;
            v1       <= 1'b0;
        end else begin
            v0 <= busy;
            v1 <= v0;
            if (page_swap) begin
                busy <= 1'b1;
            end else if (busy) begin
                // bin fastest, then pixel, then bank
                wk_bin <= (wk_bin == LAST_BIN) ? '0 : wk_bin + 1'b1;
                if (wk_bin == LAST_BIN) begin
                    wk_pixel <= (wk_pixel == LAST_PIXEL) ? '0 : wk_pixel + 1'b1;
                    if (wk_pixel == LAST_PIXEL) begin
                        wk_bank <= (wk_bank == LAST_BANK) ? '0 : wk_bank + 1'b1;
                    end
                end
                if (wk_last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // address issue and tag pipeline
    always_ff @(posedge clk) begin
        if (busy) begin
            rd_addr.pixel <= wk_pixel;
            rd_addr.bin   <= wk_bin;
            t0_bank       <= wk_bank;
            t0_pixel      <= wk_pixel;
            t0_bin        <= wk_bin;
        end
        t1_bank  <= t0_bank;
        t1_pixel <= t0_pixel;
        t1_bin   <= t0_bin;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            rd_valid   <= 1'b0;
            peak_valid <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            rd_valid   <= v1;
            peak_valid <= v1 && (t1_bin == LAST_BIN);
            // one cycle after the very last count
            frame_done <= rd_valid && (rd_bank == LAST_BANK) &&
                          (rd_pixel == LAST_PIXEL) && (rd_bin == LAST_BIN);
        end
    end

    // result stage with peak tracking
    always_ff @(posedge clk) begin
        if (v1) begin
            rd_bank  <= t1_bank;
            rd_pixel <= t1_pixel;
            rd_bin   <= t1_bin;
            rd_count <= sel_count;
            if (take_new) begin
                max_count <= sel_count;
                max_bin   <= t1_bin;
            end
            if (t1_bin == LAST_BIN) begin
                peak_bank  <= t1_bank;
                peak_pixel <= t1_pixel;
                peak_bin   <= take_new ? t1_bin : max_bin;
                peak_count <= take_new ? sel_count : max_count;
            end
        end
    end

    // a swap mid walk would flip pages under the reads in flight
    a_no_swap_busy: assert property (@(posedge clk) disable iff (!combin_res)
        page_swap |-> !(busy || v0 || v1))
        else $error("his_drain got a page swap while a walk was running");

endmodule

/* hw/his_bank.sv */
`timescale 1ns/1ps

`include "his_settings.svh"

module his_bank
    import his_readout_pkg::*;
(
    input  logic      clk,
    input  logic      combin_res,
    input  logic      hit_en,
    input  bin_addr_t hit_addr,
    input  logic      page_swap,
    input  bin_addr_t rd_addr,
    output count_t    rd_count
);

    localparam int ENTRY_NB = `PIXEL_PER_BANK * `BIN_NB;
    localparam int ADDR_W   = $bits(bin_addr_t);

    // both pages in one array
    // page bit sits above the bin address
    count_t              page_mem [2*ENTRY_NB];
    logic [ENTRY_NB-1:0] page_valid [2];

    // page currently accumulating
    logic                acc_sel;

    logic                wr_page;
    logic                rd_page;
    logic [ADDR_W-1:0]   wr_idx;
    logic [ADDR_W-1:0]   rd_idx;
    logic                hit_seen;
    count_t              old_count;
    count_t              new_count;

    // hits in the swap cycle already go to the new page
    assign wr_page = page_swap ? ~acc_sel : acc_sel;
    // readout is always the idle page
    assign rd_page = ~acc_sel;

    assign wr_idx = hit_addr;
    assign rd_idx = rd_addr;

    // new page is being invalidated this cycle
    assign hit_seen  = page_valid[wr_page][wr_idx] && !page_swap;
    assign old_count = page_mem[{wr_page, wr_idx}];

    // stale bin restarts at one
    always_comb begin
        if (!hit_seen) begin
            new_count = count_t'(1);
        end else if (old_count == COUNT_MAX) begin
            // saturate
            new_count = COUNT_MAX;
        end else begin
            new_count = old_count + 1'b1;
        end
    end

    // page select and valid bits
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            acc_sel       <= 1'b0;
            page_valid[0] <= '0;
            page_valid[1] <= '0;
        end else begin
            if (page_swap) begin
                acc_sel <= ~acc_sel;
                // wipe the whole new page at once
                page_valid[wr_page] <= '0;
            end
            // set after the wipe so a swap-cycle hit survives
            if (hit_en) begin
                page_valid[wr_page][wr_idx] <= 1'b1;
            end
        end
    end

    // read-modify-write in one cycle
    always_ff @(posedge clk) begin
        if (hit_en) begin
            page_mem[{wr_page, wr_idx}] <= new_count;
        end
    end

    // registered read port
    // invalid bins read as zero
    always_ff @(posedge clk) begin
        if (page_valid[rd_page][rd_idx]) begin
            rd_count <= page_mem[{rd_page, rd_idx}];
        end else begin
            rd_count <= '0;
        end
    end

    // select bit toggles exactly when a swap was seen
    a_sel_on_swap: assert property (@(posedge clk) disable iff (!combin_res)
        (acc_sel != $past(acc_sel)) == $past(page_swap))
        else $error("his_bank page select moved without a page swap");

endmodule

/* hw/event_router.sv */
`timescale 1ns/1ps

`include "his_settings.svh"

module event_router
    import tdc_event_pkg::*;
    import his_readout_pkg::*;
(
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 ev_strobe,
    input  event_word_u          ev_word,
    output logic [`BANK_NUM-1:0] hit_en,
    output bin_addr_t            hit_addr,
    output logic                 page_swap,
    output logic                 seq_error
);

    localparam int ACQ_W = $clog2(`ACQ_NUM + 1);

    logic              is_photon;
    logic              is_marker;
    logic              frame_end;
    logic [ACQ_W-1:0]  acq_cnt;
    logic [`SEQ_W-1:0] last_seq;
    logic [`SEQ_W-1:0] exp_seq;
    // no marker seen yet since reset
    logic              seq_seen;

    // tag is the shared msb so either view gives it
    assign is_photon = ev_strobe && (ev_word.photon.tag == EV_TAG_PHOTON);
    assign is_marker = ev_strobe && (ev_word.marker.tag == EV_TAG_MARKER);

    // next expected sequence, wraps naturally
    assign exp_seq   = last_seq + 1'b1;
    assign frame_end = (acq_cnt == ACQ_W'(`ACQ_NUM - 1));

    // one-hot bank strobe for photons
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_en <= '0;
        end else begin
            hit_en <= '0;
            if (is_photon) begin
                hit_en[ev_word.photon.bank] <= 1'b1;
            end
        end
    end

    // address shared by all banks
    always_ff @(posedge clk) begin
        if (is_photon) begin
            hit_addr.pixel <= ev_word.photon.pixel;
            hit_addr.bin   <= ev_word.photon.bin;
        end
    end

    // acquisition count and sequence tracking
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            acq_cnt   <= '0;
            page_swap <= 1'b0;
            seq_error <= 1'b0;
            last_seq  <= '0;
            seq_seen  <= 1'b0;
        end else begin
            page_swap <= 1'b0;
            seq_error <= 1'b0;
            if (is_marker) begin
                if (frame_end) begin
                    // last marker of frame
                    acq_cnt   <= '0;
                    page_swap <= 1'b1;
                end else begin
                    acq_cnt <= acq_cnt + 1'b1;
                end
                // first marker after reset always accepted
                seq_error <= seq_seen && (ev_word.marker.seq != exp_seq);
                last_seq  <= ev_word.marker.seq;
                seq_seen  <= 1'b1;
            end
        end
    end

    a_hit_onehot: assert property (@(posedge clk) disable iff (!combin_res)
        $onehot0(hit_en))
        else $error("event_router strobed more than one bank");

endmodule

/* hw/his_readout_pkg.sv */
`include "his_settings.svh"

package his_readout_pkg;

    // one entry inside a bank page
    // pixel on top so each pixel owns a block of bins
    typedef struct packed {
        logic [`PIXEL_W-1:0] pixel;
        logic [`BIN_W-1:0]   bin;
    } bin_addr_t;

    // histogram count
    typedef logic [`COUNT_W-1:0] count_t;

    // saturation ceiling
    localparam count_t COUNT_MAX = '1;

endpackage

/* hw/tdc_event_pkg.sv */
`include "his_settings.svh"

package tdc_event_pkg;

    // incoming event word width
    localparam int EV_W = 16;

    // top bit selects how the rest is read
    localparam logic EV_TAG_PHOTON = 1'b0;
    localparam logic EV_TAG_MARKER = 1'b1;

    // photon hit view
    typedef struct packed {
        logic                                       tag;
        logic [`BANK_W-1:0]                         bank;
        logic [`PIXEL_W-1:0]                        pixel;
        logic [`BIN_W-1:0]                          bin;
        logic [EV_W-2-`BANK_W-`PIXEL_W-`BIN_W:0]    spare;
    } photon_view_t;

    // acquisition marker view
    typedef struct packed {
        logic                       tag;
        logic [`SEQ_W-1:0]          seq;
        logic [EV_W-2-`SEQ_W:0]     spare;
    } marker_view_t;

    // same 16 bits decoded either way
    typedef union packed {
        photon_view_t photon;
        marker_view_t marker;
    } event_word_u;

endpackage

/* hw/his_settings.svh */
`ifndef HIS_SETTINGS_SVH
`define HIS_SETTINGS_SVH

// time bins in one pixel histogram
`define BIN_NB 16
`define BIN_W 4

// pixels served by one bank
`define PIXEL_PER_BANK 4
`define PIXEL_W 2

// bank count and bank index width
`define BANK_NUM 4
`define BANK_W 2

// markers per histogram frame
`define ACQ_NUM 3

// count width, saturates at all ones
`define COUNT_W 8
// marker sequence number width
`define SEQ_W 7

`endif
